// ==== autotest_top.f ====
source/autotest_pkg.sv
source/sd_record_pkg.sv
source/autotest_ctrl.sv
source/test_record.sv
source/uut_run_monitor.sv
source/autotest_top.sv
tb/tb_clock.sv
tb/sd_card_model.sv
tb/autotest_asserts.sv
tb/tb_autotest.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the autotest testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_autotest \
    -f autotest_top.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_autotest)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// ==== source/autotest_ctrl.sv ====
// sequencer FSM for the SD based cipher self-test
// SPI commands are levels held until busy rises, completion is busy falling
// there is no run timeout, a UUT that never ends stalls the sequencer
// a block with a bad signature stops the sequencer for good with done_o high
`timescale 1ns/100ps
`default_nettype none

module autotest_ctrl (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        spi_busy_i,
    input  wire logic                        sig_match_i,
    input  wire logic                        run_done_i,
    output logic                             spi_rst_o,
    output logic                             spi_r_block_o,
    output logic                             spi_r_byte_o,
    output logic                             spi_w_block_o,
    output logic                             spi_w_byte_o,
    output autotest_pkg::sd_addr_t           spi_block_addr_o,
    output autotest_pkg::rec_offset_t        offset_o,
    output logic                             load_o,
    output logic                             start_o,
    output logic                             capture_o,
    output logic                             rst_uut_o,
    output logic                             done_o
);

    autotest_pkg::ctrl_state_t   state_q;
    autotest_pkg::ctrl_state_t   state_d;
    autotest_pkg::rec_offset_t   offset_q;
    autotest_pkg::sd_addr_t      addr_q;
    logic                        offset_clr;
    logic                        offset_inc;
    logic                        addr_inc;
    logic                        last_byte;

    assign last_byte = (offset_q == sd_record_pkg::RECORD_LAST);

    always_comb begin
        state_d       = state_q;
        offset_clr    = 1'b0;
        offset_inc    = 1'b0;
        addr_inc      = 1'b0;
        spi_rst_o     = 1'b0;
        spi_r_block_o = 1'b0;
        spi_r_byte_o  = 1'b0;
        spi_w_block_o = 1'b0;
        spi_w_byte_o  = 1'b0;
        load_o        = 1'b0;
        start_o       = 1'b0;
        capture_o     = 1'b0;
        rst_uut_o     = 1'b1;
        done_o        = 1'b0;

        case (state_q)
            autotest_pkg::ST_IDLE: begin
                offset_clr = 1'b1;
                state_d    = autotest_pkg::ST_SPI_RST;
            end
            autotest_pkg::ST_SPI_RST: begin
                spi_rst_o = 1'b1;
                if (spi_busy_i) begin
                    state_d = autotest_pkg::ST_SPI_RST_WAIT;
                end
            end
            autotest_pkg::ST_SPI_RST_WAIT: begin
                if (!spi_busy_i) begin
                    state_d = autotest_pkg::ST_RD_BYTE;
                end
            end
            autotest_pkg::ST_RD_BYTE: begin
                spi_r_block_o = 1'b1;
                spi_r_byte_o  = 1'b1;
                if (spi_busy_i) begin
                    state_d = autotest_pkg::ST_RD_WAIT;
                end
            end
            autotest_pkg::ST_RD_WAIT: begin
                spi_r_block_o = 1'b1;
                if (!spi_busy_i) begin
                    state_d = autotest_pkg::ST_RD_LOAD;
                end
            end
            autotest_pkg::ST_RD_LOAD: begin
                // data_out is valid here, one cycle after busy fell
                spi_r_block_o = 1'b1;
                load_o        = 1'b1;
                if (last_byte) begin
                    state_d = autotest_pkg::ST_CHECK;
                end else begin
                    offset_inc = 1'b1;
                    state_d    = autotest_pkg::ST_RD_BYTE;
                end
            end
            autotest_pkg::ST_CHECK: begin
                if (sig_match_i) begin
                    state_d = autotest_pkg::ST_START;
                end else begin
                    state_d = autotest_pkg::ST_DONE;
                end
            end
            autotest_pkg::ST_START: begin
                start_o   = 1'b1;
                rst_uut_o = 1'b0;
                state_d   = autotest_pkg::ST_RUN;
            end
            autotest_pkg::ST_RUN: begin
                rst_uut_o = 1'b0;
                if (run_done_i) begin
                    state_d = autotest_pkg::ST_CAPTURE;
                end
            end
            autotest_pkg::ST_CAPTURE: begin
                // UUT still out of reset so its output is stable
                rst_uut_o  = 1'b0;
                capture_o  = 1'b1;
                offset_clr = 1'b1;
                state_d    = autotest_pkg::ST_WR_PREP;
            end
            autotest_pkg::ST_WR_PREP: begin
                // tx byte is registered after the offset step
                spi_w_block_o = 1'b1;
                state_d       = autotest_pkg::ST_WR_BYTE;
            end
            autotest_pkg::ST_WR_BYTE: begin
                spi_w_block_o = 1'b1;
                spi_w_byte_o  = 1'b1;
                if (spi_busy_i) begin
                    state_d = autotest_pkg::ST_WR_WAIT;
                end
            end
            autotest_pkg::ST_WR_WAIT: begin
                spi_w_block_o = 1'b1;
                if (!spi_busy_i) begin
                    if (last_byte) begin
                        state_d = autotest_pkg::ST_WR_FLUSH;
                    end else begin
                        offset_inc = 1'b1;
                        state_d    = autotest_pkg::ST_WR_PREP;
                    end
                end
            end
            autotest_pkg::ST_WR_FLUSH: begin
                spi_w_block_o = 1'b1;
                if (!spi_busy_i) begin
                    state_d = autotest_pkg::ST_NEXT;
                end
            end
            autotest_pkg::ST_NEXT: begin
                addr_inc = 1'b1;
                state_d  = autotest_pkg::ST_IDLE;
            end
            autotest_pkg::ST_DONE: begin
                done_o = 1'b1;
            end
            default: begin
                state_d = autotest_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= autotest_pkg::ST_IDLE;
            offset_q <= '0;
            addr_q   <= sd_record_pkg::START_BLOCK;
        end else begin
            state_q <= state_d;
            if (offset_clr) begin
                offset_q <= '0;
            end else if (offset_inc) begin
                offset_q <= offset_q + autotest_pkg::rec_offset_t'(1);
            end
            if (addr_inc) begin
                addr_q <= addr_q + autotest_pkg::sd_addr_t'(1);
            end
        end
    end

    assign offset_o         = offset_q;
    assign spi_block_addr_o = addr_q;

endmodule

`default_nettype wire

// ==== source/autotest_pkg.sv ====
// data path widths and controller states of the self-test sequencer
// byte order of multi-byte fields follows the SD record, byte i at bits 8i upward
`default_nettype none

package autotest_pkg;

    localparam int BLOCK_BYTES = 8;
    localparam int KEY_BYTES   = 10;

    typedef logic [7:0]                 byte_t;
    typedef logic [BLOCK_BYTES*8-1:0]   data_block_t;
    typedef logic [KEY_BYTES*8-1:0]     cipher_key_t;
    typedef logic [31:0]                sd_addr_t;
    typedef logic [31:0]                cycles_t;
    typedef logic [8:0]                 rec_offset_t;

    // one block per pass: spi reset, read, check, run, write, advance
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_SPI_RST,
        ST_SPI_RST_WAIT,
        ST_RD_BYTE,
        ST_RD_WAIT,
        ST_RD_LOAD,
        ST_CHECK,
        ST_START,
        ST_RUN,
        ST_CAPTURE,
        ST_WR_PREP,
        ST_WR_BYTE,
        ST_WR_WAIT,
        ST_WR_FLUSH,
        ST_NEXT,
        ST_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== source/autotest_top.sv ====
// self-test sequencer for a block cipher UUT driven from an SD card
// the SPI host and the UUT sit outside, only busy throttles the sequence
// one block is in flight at a time
`timescale 1ns/100ps
`default_nettype none

module autotest_top (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         spi_busy_i,
    input  wire autotest_pkg::byte_t          spi_data_out_i,
    output logic                              spi_rst_o,
    output logic                              spi_r_block_o,
    output logic                              spi_r_byte_o,
    output logic                              spi_w_block_o,
    output logic                              spi_w_byte_o,
    output autotest_pkg::byte_t               spi_data_in_o,
    output autotest_pkg::sd_addr_t            spi_block_addr_o,
    output logic                              rst_uut_o,
    output autotest_pkg::data_block_t         block_i_uut_o,
    output autotest_pkg::cipher_key_t         key_uut_o,
    output logic                              encdec_uut_o,
    input  wire autotest_pkg::data_block_t    block_o_uut_i,
    input  wire logic                         end_enc_uut_i,
    input  wire logic                         end_dec_uut_i,
    output logic                              done_o
);

    autotest_pkg::rec_offset_t   offset;
    autotest_pkg::cycles_t       cycles;
    logic                        load;
    logic                        capture;
    logic                        start;
    logic                        run_done;
    logic                        sig_match;

    autotest_ctrl autotest_ctrl_inst (
        .clk              (clk),
        .rst              (rst),
        .spi_busy_i       (spi_busy_i),
        .sig_match_i      (sig_match),
        .run_done_i       (run_done),
        .spi_rst_o        (spi_rst_o),
        .spi_r_block_o    (spi_r_block_o),
        .spi_r_byte_o     (spi_r_byte_o),
        .spi_w_block_o    (spi_w_block_o),
        .spi_w_byte_o     (spi_w_byte_o),
        .spi_block_addr_o (spi_block_addr_o),
        .offset_o         (offset),
        .load_o           (load),
        .start_o          (start),
        .capture_o        (capture),
        .rst_uut_o        (rst_uut_o),
        .done_o           (done_o)
    );

    test_record test_record_inst (
        .clk           (clk),
        .rst           (rst),
        .load_i        (load),
        .capture_i     (capture),
        .offset_i      (offset),
        .rx_byte_i     (spi_data_out_i),
        .block_o_uut_i (block_o_uut_i),
        .cycles_i      (cycles),
        .block_i_uut_o (block_i_uut_o),
        .key_uut_o     (key_uut_o),
        .encdec_uut_o  (encdec_uut_o),
        .sig_match_o   (sig_match),
        .tx_byte_o     (spi_data_in_o)
    );

    uut_run_monitor uut_run_monitor_inst (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start),
        .encdec_i   (encdec_uut_o),
        .end_enc_i  (end_enc_uut_i),
        .end_dec_i  (end_dec_uut_i),
        .run_done_o (run_done),
        .cycles_o   (cycles)
    );

endmodule

`default_nettype wire

// ==== source/sd_record_pkg.sv ====
// layout of the 512-byte test record held in each SD block
// offset 4 is reserved, every byte not listed here is written back as 0x00
`default_nettype none

package sd_record_pkg;

    // sent MSB first at offsets 0 to 3
    localparam logic [31:0] RECORD_SIGNATURE = 32'hAABB_CCDD;

    localparam autotest_pkg::sd_addr_t START_BLOCK = 32'h0010_0000;

    localparam autotest_pkg::rec_offset_t RECORD_LAST = 9'd511;

    // input block, bytes 5 to 12
    localparam autotest_pkg::rec_offset_t OFS_BLOCK_IN = 9'd5;

    // key, bytes 13 to 22
    localparam autotest_pkg::rec_offset_t OFS_KEY = 9'd13;

    // bit 0 set selects decrypt
    localparam autotest_pkg::rec_offset_t OFS_MODE = 9'd23;

    // output block, bytes 24 to 31
    localparam autotest_pkg::rec_offset_t OFS_BLOCK_OUT = 9'd24;

    // run cycle count, bytes 32 to 35, LSB first
    localparam autotest_pkg::rec_offset_t OFS_CYCLES = 9'd32;

endpackage

`default_nettype wire

// ==== source/test_record.sv ====
// test vector and result registers for one SD record
// loaded bytes land by record offset, the write-back byte lags the offset by one cycle
// reserved and unused offsets read back as 0x00
`timescale 1ns/100ps
`default_nettype none

module test_record (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         load_i,
    input  wire logic                         capture_i,
    input  wire autotest_pkg::rec_offset_t    offset_i,
    input  wire autotest_pkg::byte_t          rx_byte_i,
    input  wire autotest_pkg::data_block_t    block_o_uut_i,
    input  wire autotest_pkg::cycles_t        cycles_i,
    output autotest_pkg::data_block_t         block_i_uut_o,
    output autotest_pkg::cipher_key_t         key_uut_o,
    output logic                              encdec_uut_o,
    output logic                              sig_match_o,
    output autotest_pkg::byte_t               tx_byte_o
);

    logic [31:0]                 sig_q;
    autotest_pkg::byte_t         mode_q;
    autotest_pkg::data_block_t   block_in_q;
    autotest_pkg::cipher_key_t   key_q;
    autotest_pkg::data_block_t   block_out_q;
    autotest_pkg::cycles_t       cycles_q;
    autotest_pkg::byte_t         tx_d;

    // offsets relative to each field, wrap high below the field
    autotest_pkg::rec_offset_t   rel_blk;
    autotest_pkg::rec_offset_t   rel_key;
    autotest_pkg::rec_offset_t   rel_out;
    autotest_pkg::rec_offset_t   rel_cyc;
    logic                        in_sig;
    logic                        in_blk;
    logic                        in_key;
    logic                        in_out;
    logic                        in_cyc;

    assign rel_blk = offset_i - sd_record_pkg::OFS_BLOCK_IN;
    assign rel_key = offset_i - sd_record_pkg::OFS_KEY;
    assign rel_out = offset_i - sd_record_pkg::OFS_BLOCK_OUT;
    assign rel_cyc = offset_i - sd_record_pkg::OFS_CYCLES;

    assign in_sig = (offset_i < autotest_pkg::rec_offset_t'(4));
    assign in_blk = (rel_blk < autotest_pkg::rec_offset_t'(autotest_pkg::BLOCK_BYTES));
    assign in_key = (rel_key < autotest_pkg::rec_offset_t'(autotest_pkg::KEY_BYTES));
    assign in_out = (rel_out < autotest_pkg::rec_offset_t'(autotest_pkg::BLOCK_BYTES));
    assign in_cyc = (rel_cyc < autotest_pkg::rec_offset_t'(4));

    always_ff @(posedge clk) begin
        if (rst) begin
            sig_q  <= '0;
            mode_q <= '0;
        end else if (load_i) begin
            if (in_sig) begin
                // MSB arrives first
                sig_q <= {sig_q[23:0], rx_byte_i};
            end
            if (offset_i == sd_record_pkg::OFS_MODE) begin
                mode_q <= rx_byte_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_i && in_blk) begin
            block_in_q[{rel_blk[2:0], 3'b000} +: 8] <= rx_byte_i;
        end
        if (load_i && in_key) begin
            key_q[{rel_key[3:0], 3'b000} +: 8] <= rx_byte_i;
        end
        if (capture_i) begin
            block_out_q <= block_o_uut_i;
            cycles_q    <= cycles_i;
        end
    end

    always_comb begin
        tx_d = '0;
        if (in_sig) begin
            tx_d = sig_q[{~offset_i[1:0], 3'b000} +: 8];
        end else if (in_blk) begin
            tx_d = block_in_q[{rel_blk[2:0], 3'b000} +: 8];
        end else if (in_key) begin
            tx_d = key_q[{rel_key[3:0], 3'b000} +: 8];
        end else if (offset_i == sd_record_pkg::OFS_MODE) begin
            tx_d = mode_q;
        end else if (in_out) begin
            tx_d = block_out_q[{rel_out[2:0], 3'b000} +: 8];
        end else if (in_cyc) begin
            tx_d = cycles_q[{rel_cyc[1:0], 3'b000} +: 8];
        end
    end

    always_ff @(posedge clk) begin
        tx_byte_o <= tx_d;
    end

    assign sig_match_o   = (sig_q == sd_record_pkg::RECORD_SIGNATURE);
    assign block_i_uut_o = block_in_q;
    assign key_uut_o     = key_q;
    assign encdec_uut_o  = mode_q[0];

endmodule

`default_nettype wire

// ==== source/uut_run_monitor.sv ====
// run cycle counter for the UUT, on the system clock
// the end flag of the other mode is ignored, there is no timeout
`timescale 1ns/100ps
`default_nettype none

module uut_run_monitor (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                start_i,
    input  wire logic                encdec_i,
    input  wire logic                end_enc_i,
    input  wire logic                end_dec_i,
    output logic                     run_done_o,
    output autotest_pkg::cycles_t    cycles_o
);

    logic running_q;
    logic end_sel;

    // decrypt when encdec is set
    assign end_sel = encdec_i ? end_dec_i : end_enc_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            running_q  <= 1'b0;
            run_done_o <= 1'b0;
            cycles_o   <= '0;
        end else begin
            run_done_o <= 1'b0;
            if (start_i) begin
                running_q <= 1'b1;
                cycles_o  <= '0;
            end else if (running_q) begin
                // the edge that sees the flag still counts
                cycles_o <= cycles_o + autotest_pkg::cycles_t'(1);
                if (end_sel) begin
                    running_q  <= 1'b0;
                    run_done_o <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/autotest_asserts.sv ====
// SPI protocol and reset-state properties, bound into autotest_top
`timescale 1ns/100ps
`default_nettype none

module autotest_asserts (
    input wire logic                      clk,
    input wire logic                      rst,
    input wire logic                      spi_busy_i,
    input wire logic                      spi_rst_o,
    input wire logic                      spi_r_block_o,
    input wire logic                      spi_r_byte_o,
    input wire logic                      spi_w_block_o,
    input wire logic                      spi_w_byte_o,
    input wire autotest_pkg::sd_addr_t    spi_block_addr_o,
    input wire logic                      rst_uut_o,
    input wire logic                      done_o
);

    // first cycle out of reset
    assert property (@(posedge clk) $fell(rst) |-> !spi_rst_o && !spi_r_block_o
            && !spi_r_byte_o && !spi_w_block_o && !spi_w_byte_o && !done_o && rst_uut_o
            && spi_block_addr_o == sd_record_pkg::START_BLOCK)
        else $error("outputs not in reset state after reset release");

    // command levels stay up until busy is seen
    assert property (@(posedge clk) disable iff (rst)
            (spi_rst_o || spi_r_byte_o || spi_w_byte_o) && !spi_busy_i |=>
            (spi_rst_o || spi_r_byte_o || spi_w_byte_o))
        else $error("SPI strobe dropped before busy rose");

    assert property (@(posedge clk) disable iff (rst) !(spi_r_block_o && spi_w_block_o))
        else $error("read and write block active together");

    assert property (@(posedge clk) disable iff (rst)
            (spi_rst_o || spi_r_block_o || spi_w_block_o) |-> rst_uut_o)
        else $error("UUT out of reset during an SPI transfer");

    assert property (@(posedge clk) disable iff (rst) done_o |=> done_o)
        else $error("done_o dropped");

endmodule

bind autotest_top autotest_asserts autotest_asserts_inst (.*);

`default_nettype wire

// ==== tb/sd_card_model.sv ====
// behavioral SPI host with four SD blocks from START_BLOCK upward
// strobes are sampled at the falling edge, busy and data change 1 ns after the rising edge
// busy stays high 1 to 4 cycles, drawn from $random with seed 70
`timescale 1ns/100ps
`default_nettype none

module sd_card_model (
    input  wire logic          clk_i,
    input  wire logic          rst_i,
    input  wire logic          spi_rst_i,
    input  wire logic          spi_r_byte_i,
    input  wire logic          spi_w_byte_i,
    input  wire logic [7:0]    spi_data_in_i,
    input  wire logic [31:0]   spi_block_addr_i,
    output logic               spi_busy_o,
    output logic [7:0]         spi_data_out_o
);

    // image of the card, filled by the testbench
    logic [7:0]  mem [0:3][0:511];
    // bytes written back, and which blocks got a full record
    logic [7:0]  wr_mem [0:3][0:511];
    logic        written [0:3];

    integer      seed;
    int          hold;
    int          rd_cnt;
    int          wr_cnt;
    logic        s_rst;
    logic        s_cmd_rst;
    logic        s_rd;
    logic        s_wr;
    logic [7:0]  s_din;
    logic [31:0] s_addr;
    logic [1:0]  blk;
    logic [7:0]  pending;

    task automatic raise_busy();
        spi_busy_o = 1'b1;
        hold = 1 + ($random(seed) & 3);
    endtask

    initial begin
        seed = 70;
        hold = 0;
        rd_cnt = 0;
        wr_cnt = 0;
        pending = 8'h00;
        spi_busy_o = 1'b0;
        spi_data_out_o = 8'h00;
        for (int b = 0; b < 4; b++) begin
            written[b] = 1'b0;
        end
    end

    always begin
        @(negedge clk_i);
        s_rst = rst_i;
        s_cmd_rst = spi_rst_i;
        s_rd = spi_r_byte_i;
        s_wr = spi_w_byte_i;
        s_din = spi_data_in_i;
        s_addr = spi_block_addr_i;
        @(posedge clk_i);
        #1;
        blk = 2'(s_addr - sd_record_pkg::START_BLOCK);
        if (s_rst) begin
            spi_busy_o = 1'b0;
        end else if (spi_busy_o) begin
            if (hold > 1) begin
                hold = hold - 1;
            end else begin
                spi_busy_o = 1'b0;
                spi_data_out_o = pending;
            end
        end else if (s_cmd_rst) begin
            rd_cnt = 0;
            wr_cnt = 0;
            raise_busy();
        end else if (s_rd) begin
            pending = mem[blk][rd_cnt[8:0]];
            rd_cnt = rd_cnt + 1;
            raise_busy();
        end else if (s_wr) begin
            wr_mem[blk][wr_cnt[8:0]] = s_din;
            if (wr_cnt == 511) begin
                written[blk] = 1'b1;
            end
            wr_cnt = wr_cnt + 1;
            raise_busy();
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_autotest.sv ====
// three valid records followed by one with a bad signature
// the UUT stand-in answers RUN_CYCLES after release and pulses the other end flag early
`timescale 1ns/100ps
`default_nettype none

module tb_autotest;

    localparam int RUN_CYCLES  = 12;
    localparam int EARLY_CYCLE = 3;
    localparam int NUM_VALID   = 3;
    localparam int WAIT_LIMIT  = 200000;

    logic                        clk;
    logic                        rst;
    logic                        spi_busy;
    logic [7:0]                  spi_data_out;
    logic                        spi_rst;
    logic                        spi_r_block;
    logic                        spi_r_byte;
    logic                        spi_w_block;
    logic                        spi_w_byte;
    logic [7:0]                  spi_data_in;
    autotest_pkg::sd_addr_t      spi_block_addr;
    logic                        rst_uut;
    autotest_pkg::data_block_t   block_i_uut;
    autotest_pkg::cipher_key_t   key_uut;
    logic                        encdec_uut;
    autotest_pkg::data_block_t   block_o_uut;
    logic                        end_enc;
    logic                        end_dec;
    logic                        done;

    autotest_pkg::data_block_t   vec_block [0:3];
    autotest_pkg::cipher_key_t   vec_key [0:3];
    logic [7:0]                  vec_mode [0:3];
    integer                      seed;
    int                          runs;
    int                          uut_cnt;

    tb_clock tb_clock_inst (.clk_o(clk), .rst_o(rst));

    sd_card_model sd_card_model_inst (
        .clk_i(clk), .rst_i(rst), .spi_rst_i(spi_rst), .spi_r_byte_i(spi_r_byte),
        .spi_w_byte_i(spi_w_byte), .spi_data_in_i(spi_data_in),
        .spi_block_addr_i(spi_block_addr), .spi_busy_o(spi_busy),
        .spi_data_out_o(spi_data_out)
    );

    autotest_top autotest_top_inst (
        .clk(clk), .rst(rst), .spi_busy_i(spi_busy), .spi_data_out_i(spi_data_out),
        .spi_rst_o(spi_rst), .spi_r_block_o(spi_r_block), .spi_r_byte_o(spi_r_byte),
        .spi_w_block_o(spi_w_block), .spi_w_byte_o(spi_w_byte),
        .spi_data_in_o(spi_data_in), .spi_block_addr_o(spi_block_addr),
        .rst_uut_o(rst_uut), .block_i_uut_o(block_i_uut), .key_uut_o(key_uut),
        .encdec_uut_o(encdec_uut), .block_o_uut_i(block_o_uut),
        .end_enc_uut_i(end_enc), .end_dec_uut_i(end_dec), .done_o(done)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_hex(input string name, input logic [79:0] got,
                             input logic [79:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic autotest_pkg::data_block_t expected_result(input int b);
        autotest_pkg::data_block_t r;
        r = vec_block[b] ^ vec_key[b][63:0];
        if (vec_mode[b][0]) begin
            r = ~r;
        end
        return r;
    endfunction

    // card image byte before any write-back
    function automatic logic [7:0] image_byte(input int b, input int i);
        logic [31:0] sig;
        int          a;
        sig = (b == NUM_VALID) ? 32'hAABB_CCDE : sd_record_pkg::RECORD_SIGNATURE;
        a = b * 512 + i;
        if (i < 4) return sig[31 - 8 * i -: 8];
        if (i == 4) return 8'h5A;
        if (i < 13) return vec_block[b][8 * (i - 5) +: 8];
        if (i < 23) return vec_key[b][8 * (i - 13) +: 8];
        if (i == 23) return vec_mode[b];
        return 8'((a * 37) ^ (a >> 8) ^ 8'hC3);
    endfunction

    function automatic logic [7:0] written_byte(input int b, input int i);
        autotest_pkg::data_block_t r;
        r = expected_result(b);
        if (i == 4) return 8'h00;
        if (i < 24) return image_byte(b, i);
        if (i < 32) return r[8 * (i - 24) +: 8];
        return 8'h00;
    endfunction

    // stand-in UUT driven 1 ns after the rising edge
    always begin
        @(posedge clk);
        #1;
        if (rst_uut) begin
            uut_cnt = 0;
            end_enc = 1'b0;
            end_dec = 1'b0;
            block_o_uut = 64'h0BAD_0BAD_0BAD_0BAD;
        end else begin
            uut_cnt = uut_cnt + 1;
            if (encdec_uut) begin
                end_enc = (uut_cnt == EARLY_CYCLE);
            end else begin
                end_dec = (uut_cnt == EARLY_CYCLE);
            end
            if (uut_cnt > RUN_CYCLES) begin
                block_o_uut = block_i_uut ^ key_uut[63:0] ^ {64{encdec_uut}};
                if (encdec_uut) begin
                    end_dec = 1'b1;
                end else begin
                    end_enc = 1'b1;
                end
            end
        end
    end

    // blocks are run in order from START_BLOCK
    always @(negedge rst_uut) begin
        if (runs >= NUM_VALID) begin
            fail_now("UUT released for a block without a valid record");
        end else begin
            check_hex("spi_block_addr_o", 80'(spi_block_addr),
                      80'(sd_record_pkg::START_BLOCK + runs));
            check_hex("block_i_uut_o", 80'(block_i_uut), 80'(vec_block[runs]));
            check_hex("key_uut_o", key_uut, vec_key[runs]);
            check_hex("encdec_uut_o", 80'(encdec_uut), 80'(vec_mode[runs][0]));
            runs = runs + 1;
        end
    end

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst && n < 100) begin
            @(posedge clk);
            n = n + 1;
        end
        if (rst) fail_now("reset never released");
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < WAIT_LIMIT) begin
            @(posedge clk);
            n = n + 1;
        end
        if (!done) fail_now("timeout waiting for done_o");
    endtask

    task automatic check_records();
        logic [31:0] cyc;
        for (int b = 0; b < NUM_VALID; b++) begin
            if (!sd_card_model_inst.written[b]) begin
                fail_now($sformatf("block %0d was never written back", b));
            end
            for (int i = 0; i < 512; i++) begin
                if (i < 32 || i > 35) begin
                    check_hex($sformatf("spi_data_in_o block %0d byte %0d", b, i),
                              80'(sd_card_model_inst.wr_mem[b][i]),
                              80'(written_byte(b, i)));
                end
            end
            cyc = {sd_card_model_inst.wr_mem[b][35], sd_card_model_inst.wr_mem[b][34],
                   sd_card_model_inst.wr_mem[b][33], sd_card_model_inst.wr_mem[b][32]};
            if (cyc < RUN_CYCLES || cyc > RUN_CYCLES + 2) begin
                fail_now($sformatf("CHECK FAILED cycles block %0d got %h expected %h to %h",
                                   b, cyc, RUN_CYCLES, RUN_CYCLES + 2));
            end
        end
        if (sd_card_model_inst.written[NUM_VALID]) begin
            fail_now("block with bad signature was written back");
        end
    endtask

    initial begin
        seed = 70;
        runs = 0;
        uut_cnt = 0;
        end_enc = 1'b0;
        end_dec = 1'b0;
        block_o_uut = '0;
        for (int b = 0; b < 4; b++) begin
            vec_block[b] = {$random(seed), $random(seed)};
            vec_key[b] = {$random(seed), $random(seed), 16'($random(seed))};
        end
        vec_mode[0] = 8'h00;
        vec_mode[1] = 8'h01;
        vec_mode[2] = 8'h03;
        vec_mode[3] = 8'h00;
        for (int b = 0; b < 4; b++) begin
            for (int i = 0; i < 512; i++) begin
                sd_card_model_inst.mem[b][i] = image_byte(b, i);
            end
        end
        wait_reset_release();
        wait_done();
        // parked for good on the bad block
        repeat (50) begin
            @(posedge clk);
            check_hex("done_o", 80'(done), 80'(1'b1));
            check_hex("spi_block_addr_o", 80'(spi_block_addr),
                      80'(sd_record_pkg::START_BLOCK + NUM_VALID));
        end
        check_records();
        if (runs != NUM_VALID) begin
            fail_now($sformatf("CHECK FAILED runs got %h expected %h", runs, NUM_VALID));
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
// 20 ns clock, reset held high for the first 10 rising edges
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (10) @(posedge clk_o);
        #1 rst_o = 1'b0;
    end

endmodule

`default_nettype wire
